// File: hw/mem_test_pkg.sv
/*
 * Widths, register indices and packed structs shared by the memory
 * test engine RTL and its testbench
 */
package mem_test_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================

    // Line address width
    localparam int ADDR_WIDTH = 32;
    // Data bits per line
    localparam int LINE_WIDTH = 128;
    // Burst length field, lengths 1 to 255
    localparam int BURST_WIDTH = 8;
    // Offset counter and address mask
    localparam int ADDR_LOW_WIDTH = 15;
    // Burst limit field
    localparam int NUM_BURSTS_WIDTH = 16;

    // Top half of every written line
    localparam logic [63:0] WR_MARKER = 64'h5a5a_c3c3_0f0f_a5a5;

    // ==========================================================
    // Register indices
    // ==========================================================

    // Control writes use these, status reads 0 to 5 reuse the numbers
    localparam logic [2:0] CSR_RD_BASE = 3'd0;
    localparam logic [2:0] CSR_WR_BASE = 3'd1;
    localparam logic [2:0] CSR_RD_CTRL = 3'd2;
    localparam logic [2:0] CSR_WR_CTRL = 3'd3;
    localparam logic [2:0] CSR_MASK = 3'd4;
    localparam logic [2:0] CSR_CMD = 3'd5;

    // ==========================================================
    // Types
    // ==========================================================

    typedef logic [ADDR_WIDTH-1:0] t_addr;
    typedef logic [LINE_WIDTH-1:0] t_line;
    typedef logic [ADDR_LOW_WIDTH-1:0] t_addr_low;
    typedef logic [BURST_WIDTH-1:0] t_burst;

    // Register write from the host
    typedef struct packed {
        logic valid;
        logic [2:0] idx;
        logic [63:0] data;
    } t_csr_wr;

    // Settings for one traffic direction
    typedef struct packed {
        t_addr base_addr;
        t_addr_low start_offset;
        t_burst burst_len;
        // Zero means no limit
        logic [NUM_BURSTS_WIDTH-1:0] num_bursts;
    } t_traffic_cfg;

    typedef struct packed {
        t_addr addr;
        t_burst burst_len;
    } t_rd_req;

    typedef struct packed {
        t_addr addr;
        t_burst burst_len;
        // First line of a burst
        logic sop;
        t_line data;
    } t_wr_line;

endpackage

// File: hw/line_fifo.sv
/*
 * Synchronous register-array FIFO for any payload type,
 * valid/ready on both sides
 */
`timescale 1ns/10ps

module line_fifo
#(
    parameter type ITEM_T = logic [7:0],
    parameter int DEPTH = 8
)
(
    input  logic clk,
    input  logic state_reset,
    input  ITEM_T in_data,
    input  logic in_valid,
    output logic in_ready,
    output ITEM_T out_data,
    output logic out_valid,
    input  logic out_ready,
    output logic empty
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    ITEM_T mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic push;
    logic pop;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready = (count != COUNT_WIDTH'(DEPTH));
    assign out_valid = (count != '0);
    assign empty = (count == '0);
    assign out_data = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop);
        end
    end

    // A stalled head entry holds, and a full FIFO never overwrites it
    a_no_push_when_full: assert property (@(posedge clk) disable iff (state_reset)
        (out_valid && !out_ready) |=> $stable(out_data));

endmodule

// File: hw/csr_regs.sv
/*
 * Control register decode, start and run bits, status read mux
 * and the registered engine active flag
 */
`timescale 1ns/10ps

module csr_regs
#(
    parameter int CNT_WIDTH = 48
)
(
    input  logic clk,
    input  logic state_reset,
    input  mem_test_pkg::t_csr_wr csr_wr,
    input  logic [2:0] csr_rd_idx,
    output logic [63:0] csr_rd_data,
    output mem_test_pkg::t_traffic_cfg rd_cfg,
    output mem_test_pkg::t_traffic_cfg wr_cfg,
    output mem_test_pkg::t_addr_low addr_mask,
    output logic start,
    output logic run,
    input  logic [CNT_WIDTH-1:0] rd_bursts,
    input  logic [CNT_WIDTH-1:0] rd_lines,
    input  logic [CNT_WIDTH-1:0] wr_lines,
    input  logic [CNT_WIDTH-1:0] wr_bursts_resp,
    input  logic [31:0] rd_sum,
    input  logic [31:0] rd_hash,
    input  logic rd_busy,
    input  logic wr_busy,
    output logic active
);

    // Largest burst reported to software
    localparam logic [14:0] MAX_BURST = 15'd128;

    logic [63:0] status_cfg;

    // Control word layout shared by read and write control
    function automatic mem_test_pkg::t_traffic_cfg load_ctrl(
        input mem_test_pkg::t_traffic_cfg cur,
        input logic [63:0] data
    );
        mem_test_pkg::t_traffic_cfg cfg;
        cfg = cur;
        cfg.num_bursts = data[47:32];
        cfg.start_offset = data[16 +: mem_test_pkg::ADDR_LOW_WIDTH];
        cfg.burst_len = data[7:0];
        return cfg;
    endfunction

    // ==========================================================
    // Control registers
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            rd_cfg <= '0;
            wr_cfg <= '0;
            addr_mask <= '0;
            start <= 1'b0;
            run <= 1'b0;
        end
        else
        begin
            // Start is a single cycle pulse
            start <= 1'b0;
            if (csr_wr.valid)
            begin
                case (csr_wr.idx)
                    mem_test_pkg::CSR_RD_BASE:
                        rd_cfg.base_addr <= csr_wr.data[mem_test_pkg::ADDR_WIDTH-1:0];
                    mem_test_pkg::CSR_WR_BASE:
                        wr_cfg.base_addr <= csr_wr.data[mem_test_pkg::ADDR_WIDTH-1:0];
                    mem_test_pkg::CSR_RD_CTRL:
                        rd_cfg <= load_ctrl(rd_cfg, csr_wr.data);
                    mem_test_pkg::CSR_WR_CTRL:
                        wr_cfg <= load_ctrl(wr_cfg, csr_wr.data);
                    mem_test_pkg::CSR_MASK:
                        addr_mask <= csr_wr.data[mem_test_pkg::ADDR_LOW_WIDTH-1:0];
                    mem_test_pkg::CSR_CMD:
                    begin
                        start <= csr_wr.data[0];
                        run <= csr_wr.data[1];
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // Start counts as busy so active rises the cycle after it
    always_ff @(posedge clk)
    begin
        if (state_reset)
            active <= 1'b0;
        else
            active <= start || rd_busy || wr_busy;
    end

    // ==========================================================
    // Status read mux
    // ==========================================================

    // Ordered responses, burst count write responses, engine type 1
    assign status_cfg = {24'h0, 1'b1, 1'b0, 3'd1, active, run, 1'b0,
                         16'(mem_test_pkg::ADDR_LOW_WIDTH), 1'b0, MAX_BURST};

    always_comb
    begin
        case (csr_rd_idx)
            3'd0: csr_rd_data = status_cfg;
            3'd1: csr_rd_data = 64'(rd_bursts);
            3'd2: csr_rd_data = 64'(rd_lines);
            3'd3: csr_rd_data = 64'(wr_lines);
            3'd4: csr_rd_data = 64'(wr_bursts_resp);
            3'd5: csr_rd_data = {rd_sum, rd_hash};
            default: csr_rd_data = 64'h0;
        endcase
    end

endmodule

// File: hw/rd_req_gen.sv
/*
 * Read burst request producer with masked address stepping,
 * burst limit and request counters
 */
`timescale 1ns/10ps

module rd_req_gen
#(
    parameter int CNT_WIDTH = 48
)
(
    input  logic clk,
    input  logic state_reset,
    input  logic start,
    input  logic run,
    input  mem_test_pkg::t_traffic_cfg cfg,
    input  mem_test_pkg::t_addr_low addr_mask,
    output mem_test_pkg::t_rd_req req,
    output logic req_valid,
    input  logic req_ready,
    output logic [CNT_WIDTH-1:0] bursts_req,
    output logic [CNT_WIDTH-1:0] lines_req,
    output logic done
);

    mem_test_pkg::t_addr_low offset;
    logic [mem_test_pkg::NUM_BURSTS_WIDTH-1:0] bursts_left;
    logic unlimited;
    logic accept;

    // Base OR masked offset, the base is aligned to the mask
    assign req.addr = cfg.base_addr | mem_test_pkg::t_addr'(offset & addr_mask);
    assign req.burst_len = cfg.burst_len;
    assign req_valid = run && !done;
    assign accept = req_valid && req_ready;

    // Offset and remaining bursts
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            offset <= cfg.start_offset;
            bursts_left <= cfg.num_bursts;
            unlimited <= (cfg.num_bursts == '0);
        end
        else if (accept)
        begin
            offset <= offset + mem_test_pkg::t_addr_low'(cfg.burst_len);
            bursts_left <= bursts_left - 1'b1;
        end
    end

    // Done flag and request counters
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            done <= 1'b1;
            bursts_req <= '0;
            lines_req <= '0;
        end
        else if (start)
        begin
            // No base address means no read traffic
            done <= (cfg.base_addr == '0);
            bursts_req <= '0;
            lines_req <= '0;
        end
        else if (accept)
        begin
            done <= !unlimited && (bursts_left == 1);
            bursts_req <= bursts_req + 1'b1;
            lines_req <= lines_req + CNT_WIDTH'(cfg.burst_len);
        end
    end

    // Request held until the memory takes it
    a_req_stable: assert property (@(posedge clk) disable iff (state_reset)
        (req_valid && !req_ready && !start) |=> $stable(req));

endmodule

// File: hw/wr_burst_gen.sv
/*
 * Write line producer with burst tracking, line marking and
 * write response counting
 */
`timescale 1ns/10ps

module wr_burst_gen
#(
    parameter int CNT_WIDTH = 48
)
(
    input  logic clk,
    input  logic state_reset,
    input  logic start,
    input  logic run,
    input  mem_test_pkg::t_traffic_cfg cfg,
    input  mem_test_pkg::t_addr_low addr_mask,
    output mem_test_pkg::t_wr_line line,
    output logic line_valid,
    input  logic line_ready,
    input  logic wr_resp_valid,
    output logic [CNT_WIDTH-1:0] lines_sent,
    output logic [CNT_WIDTH-1:0] bursts_resp,
    output logic busy
);

    mem_test_pkg::t_addr_low offset;
    mem_test_pkg::t_burst beats_left;
    logic [mem_test_pkg::NUM_BURSTS_WIDTH-1:0] bursts_left;
    logic unlimited;
    logic done;
    logic sop;
    logic push;
    logic last_beat;
    logic [CNT_WIDTH-1:0] bursts_sent;

    // One address per line
    always_comb
    begin
        line.addr = cfg.base_addr | mem_test_pkg::t_addr'(offset & addr_mask);
        line.burst_len = cfg.burst_len;
        line.sop = sop;
        line.data = {mem_test_pkg::WR_MARKER, 64'(line.addr)};
    end

    // Mid-burst lines go out even after run drops
    assign line_valid = (run && !done) || !sop;
    assign push = line_valid && line_ready;
    assign last_beat = (beats_left == 1);

    // Unfinished bursts or bursts still waiting for a response
    assign busy = (run && !done) || !sop || (bursts_sent != bursts_resp);

    // Address and burst position
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            offset <= cfg.start_offset;
            beats_left <= cfg.burst_len;
            bursts_left <= cfg.num_bursts;
            unlimited <= (cfg.num_bursts == '0);
        end
        else if (push)
        begin
            offset <= offset + 1'b1;
            beats_left <= last_beat ? cfg.burst_len : beats_left - 1'b1;
            if (last_beat)
                bursts_left <= bursts_left - 1'b1;
        end
    end

    // ==========================================================
    // Run state and counters
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (state_reset || start)
        begin
            done <= state_reset || (cfg.base_addr == '0);
            sop <= 1'b1;
            lines_sent <= '0;
            bursts_sent <= '0;
            bursts_resp <= '0;
        end
        else
        begin
            if (push)
            begin
                lines_sent <= lines_sent + 1'b1;
                sop <= last_beat;
                if (last_beat)
                begin
                    bursts_sent <= bursts_sent + 1'b1;
                    done <= !unlimited && (bursts_left == 1);
                end
            end
            // One response per completed burst
            if (wr_resp_valid)
                bursts_resp <= bursts_resp + 1'b1;
        end
    end

endmodule

// File: hw/rd_checker.sv
/*
 * Read response consumer with line count, checksum and
 * rolling hash over the returned data
 */
`timescale 1ns/10ps

module rd_checker
#(
    parameter int CNT_WIDTH = 48
)
(
    input  logic clk,
    input  logic state_reset,
    input  logic start,
    input  mem_test_pkg::t_line line,
    input  logic line_valid,
    output logic line_ready,
    output logic [CNT_WIDTH-1:0] lines_resp,
    output logic [31:0] sum,
    output logic [31:0] hash
);

    logic [31:0] sample;
    logic sample_valid;

    // Checker never stalls the read FIFO
    assign line_ready = 1'b1;

    // Top and bottom 16 bits of each line, registered before folding
    always_ff @(posedge clk)
    begin
        sample <= {line[mem_test_pkg::LINE_WIDTH-1 -: 16], line[15:0]};
    end

    always_ff @(posedge clk)
    begin
        if (state_reset || start)
        begin
            sample_valid <= 1'b0;
            lines_resp <= '0;
            sum <= '0;
            hash <= '0;
        end
        else
        begin
            sample_valid <= line_valid;
            if (line_valid)
                lines_resp <= lines_resp + 1'b1;
            // Sum wraps at 32 bits, hash rotates left by 5
            if (sample_valid)
            begin
                sum <= sum + sample;
                hash <= {hash[26:0], hash[31:27]} ^ sample;
            end
        end
    end

endmodule

// File: hw/mem_test_engine.sv
/*
 * Memory test engine top level with registers, traffic
 * generators, line FIFOs and read checker
 */
`timescale 1ns/10ps

module mem_test_engine
#(
    parameter int CNT_WIDTH = 48,
    parameter int WR_FIFO_DEPTH = 8,
    parameter int RD_FIFO_DEPTH = 16
)
(
    input  logic clk,
    input  logic state_reset,
    input  mem_test_pkg::t_csr_wr csr_wr,
    input  logic [2:0] csr_rd_idx,
    output logic [63:0] csr_rd_data,
    output mem_test_pkg::t_rd_req rd_req,
    output logic rd_req_valid,
    input  logic rd_req_ready,
    input  mem_test_pkg::t_line rd_resp,
    input  logic rd_resp_valid,
    output logic rd_resp_ready,
    output mem_test_pkg::t_wr_line wr_line,
    output logic wr_line_valid,
    input  logic wr_line_ready,
    input  logic wr_resp_valid,
    output logic active
);

    mem_test_pkg::t_traffic_cfg rd_cfg;
    mem_test_pkg::t_traffic_cfg wr_cfg;
    mem_test_pkg::t_addr_low addr_mask;
    logic start;
    logic run;
    logic [CNT_WIDTH-1:0] rd_bursts;
    logic [CNT_WIDTH-1:0] rd_lines_req;
    logic [CNT_WIDTH-1:0] rd_lines;
    logic [CNT_WIDTH-1:0] wr_lines;
    logic [CNT_WIDTH-1:0] wr_bursts_resp;
    logic [31:0] rd_sum;
    logic [31:0] rd_hash;
    logic rd_done;
    logic wr_gen_busy;
    logic rd_busy;
    logic wr_busy;
    mem_test_pkg::t_wr_line gen_line;
    logic gen_line_valid;
    logic gen_line_ready;
    mem_test_pkg::t_line chk_line;
    logic chk_line_valid;
    logic chk_line_ready;
    logic wr_fifo_empty;
    logic rd_fifo_empty;

    // Busy until generators finish, FIFOs drain and responses are in
    assign rd_busy = (run && !rd_done) || (rd_lines_req != rd_lines) || !rd_fifo_empty;
    assign wr_busy = wr_gen_busy || !wr_fifo_empty;

    csr_regs #(.CNT_WIDTH(CNT_WIDTH)) i_csr_regs (
        .clk, .state_reset, .csr_wr, .csr_rd_idx, .csr_rd_data,
        .rd_cfg, .wr_cfg, .addr_mask, .start, .run,
        .rd_bursts, .rd_lines, .wr_lines, .wr_bursts_resp,
        .rd_sum, .rd_hash, .rd_busy, .wr_busy, .active
    );

    // ==========================================================
    // Read path
    // ==========================================================

    rd_req_gen #(.CNT_WIDTH(CNT_WIDTH)) i_rd_req_gen (
        .clk, .state_reset, .start, .run, .cfg(rd_cfg), .addr_mask,
        .req(rd_req), .req_valid(rd_req_valid), .req_ready(rd_req_ready),
        .bursts_req(rd_bursts), .lines_req(rd_lines_req), .done(rd_done)
    );

    line_fifo #(.ITEM_T(mem_test_pkg::t_line), .DEPTH(RD_FIFO_DEPTH)) i_rd_fifo (
        .clk, .state_reset,
        .in_data(rd_resp), .in_valid(rd_resp_valid), .in_ready(rd_resp_ready),
        .out_data(chk_line), .out_valid(chk_line_valid), .out_ready(chk_line_ready),
        .empty(rd_fifo_empty)
    );

    rd_checker #(.CNT_WIDTH(CNT_WIDTH)) i_rd_checker (
        .clk, .state_reset, .start,
        .line(chk_line), .line_valid(chk_line_valid), .line_ready(chk_line_ready),
        .lines_resp(rd_lines), .sum(rd_sum), .hash(rd_hash)
    );

    // ==========================================================
    // Write path
    // ==========================================================

    wr_burst_gen #(.CNT_WIDTH(CNT_WIDTH)) i_wr_burst_gen (
        .clk, .state_reset, .start, .run, .cfg(wr_cfg), .addr_mask,
        .line(gen_line), .line_valid(gen_line_valid), .line_ready(gen_line_ready),
        .wr_resp_valid, .lines_sent(wr_lines), .bursts_resp(wr_bursts_resp),
        .busy(wr_gen_busy)
    );

    line_fifo #(.ITEM_T(mem_test_pkg::t_wr_line), .DEPTH(WR_FIFO_DEPTH)) i_wr_fifo (
        .clk, .state_reset,
        .in_data(gen_line), .in_valid(gen_line_valid), .in_ready(gen_line_ready),
        .out_data(wr_line), .out_valid(wr_line_valid), .out_ready(wr_line_ready),
        .empty(wr_fifo_empty)
    );

endmodule

// File: tests/host_mem_model.sv
/*
 * Behavioral host memory for the test engine with seeded random
 * ready, read line generation and write burst checking
 */
`timescale 1ns/10ps

module host_mem_model
(
    input  logic clk,
    input  logic state_reset,
    input  logic rand_ready,
    input  mem_test_pkg::t_rd_req rd_req,
    input  logic rd_req_valid,
    output logic rd_req_ready,
    output mem_test_pkg::t_line rd_resp,
    output logic rd_resp_valid,
    input  logic rd_resp_ready,
    input  mem_test_pkg::t_wr_line wr_line,
    input  logic wr_line_valid,
    output logic wr_line_ready,
    output logic wr_resp_valid,
    output int error_count
);

    int seed = 32'h5e89_f093;
    // Line addresses still to be returned, in request order
    mem_test_pkg::t_addr pending [$];
    mem_test_pkg::t_burst cur_len;
    int beat;
    logic resp_due;
    logic resp_taken;

    // Upper and lower halves both hold address times 3 plus 1
    function automatic mem_test_pkg::t_line line_data(input mem_test_pkg::t_addr addr);
        logic [63:0] v;
        v = 64'(addr) * 64'd3 + 64'd1;
        return {v, v};
    endfunction

    // Ready or valid gate, always open unless random mode is on
    function automatic logic coin();
        logic [31:0] r;
        r = $random(seed);
        return rand_ready ? r[0] : 1'b1;
    endfunction

    // Data, framing and burst end of one accepted write line
    task automatic check_write();
        logic [127:0] exp_data;
        exp_data = {mem_test_pkg::WR_MARKER, 64'(wr_line.addr)};
        assert (wr_line.data == exp_data)
        else
        begin
            $display("FAIL %0t wr_line.data got %h expected %h", $time, wr_line.data, exp_data);
            error_count++;
        end
        if (beat == 0)
        begin
            cur_len = wr_line.burst_len;
            assert (wr_line.sop)
            else
            begin
                $display("Write line at %0t opens a burst but has no start flag", $time);
                error_count++;
            end
        end
        else
        begin
            assert (!wr_line.sop)
            else
            begin
                $display("Write line at %0t has a start flag in mid burst", $time);
                error_count++;
            end
        end
        beat++;
        if (beat == int'(cur_len))
        begin
            beat = 0;
            resp_due = 1'b1;
        end
    endtask

    initial
    begin
        int i;
        rd_req_ready = 1'b0;
        rd_resp = '0;
        rd_resp_valid = 1'b0;
        wr_line_ready = 1'b0;
        wr_resp_valid = 1'b0;
        error_count = 0;
        cur_len = '0;
        beat = 0;
        resp_due = 1'b0;
        resp_taken = 1'b0;
        forever
        begin
            // Handshakes of the coming edge, sampled mid cycle
            @(negedge clk);
            if (state_reset)
            begin
                pending.delete();
                beat = 0;
                resp_due = 1'b0;
                resp_taken = 1'b0;
            end
            else
            begin
                if (rd_req_valid && rd_req_ready)
                begin
                    for (i = 0; i < int'(rd_req.burst_len); i++)
                        pending.push_back(rd_req.addr + mem_test_pkg::t_addr'(i));
                end
                resp_taken = rd_resp_valid && rd_resp_ready;
                if (resp_taken)
                    void'(pending.pop_front());
                if (wr_line_valid && wr_line_ready)
                    check_write();
            end

            // New drive values just after the edge
            @(posedge clk);
            #1;
            rd_req_ready = coin();
            wr_line_ready = coin();
            wr_resp_valid = resp_due;
            resp_due = 1'b0;
            // A line not yet taken stays on the bus
            if (!(rd_resp_valid && !resp_taken))
            begin
                rd_resp_valid = (pending.size() > 0) && coin();
                if (rd_resp_valid)
                    rd_resp = line_data(pending[0]);
            end
        end
    end

endmodule

// File: tests/tb_mem_test_engine.sv
/*
 * Testbench for the memory test engine with clock, reset, row table
 * of read and write runs, bus monitors and expected value checks
 */
`timescale 1ns/10ps

module tb_mem_test_engine;

    localparam int NUM_ROWS = 6;

    // One run, rows 3 to 5 repeat 0 to 2 under random ready
    typedef struct packed {
        logic [31:0] rd_base;
        logic [15:0] rd_n;
        logic [14:0] rd_start;
        logic [7:0] rd_len;
        logic [31:0] wr_base;
        logic [15:0] wr_n;
        logic [14:0] wr_start;
        logic [7:0] wr_len;
        logic [14:0] mask;
        logic rand_ready;
        logic [15:0] exp_rd_bursts;
        logic [15:0] exp_rd_lines;
        logic [15:0] exp_wr_lines;
        logic [15:0] exp_wr_bursts;
    } t_row;

    logic clk = 1'b0;
    logic state_reset;
    mem_test_pkg::t_csr_wr csr_wr;
    logic [2:0] csr_rd_idx;
    logic [63:0] csr_rd_data;
    mem_test_pkg::t_rd_req rd_req;
    logic rd_req_valid;
    logic rd_req_ready;
    mem_test_pkg::t_line rd_resp;
    logic rd_resp_valid;
    logic rd_resp_ready;
    mem_test_pkg::t_wr_line wr_line;
    logic wr_line_valid;
    logic wr_line_ready;
    logic wr_resp_valid;
    logic active;
    logic rand_ready;
    int mem_errors;

    t_row rows [NUM_ROWS];
    int errors = 0;
    int cycles = 0;
    int timeout_limit = 0;
    mem_test_pkg::t_addr seen_rd [$];
    mem_test_pkg::t_addr seen_wr [$];
    logic [31:0] exp_sum;
    logic [31:0] exp_hash;

    always #4 clk = ~clk;

    mem_test_engine i_mem_test_engine (
        .clk, .state_reset, .csr_wr, .csr_rd_idx, .csr_rd_data,
        .rd_req, .rd_req_valid, .rd_req_ready,
        .rd_resp, .rd_resp_valid, .rd_resp_ready,
        .wr_line, .wr_line_valid, .wr_line_ready,
        .wr_resp_valid, .active
    );

    host_mem_model i_host_mem (
        .clk, .state_reset, .rand_ready,
        .rd_req, .rd_req_valid, .rd_req_ready,
        .rd_resp, .rd_resp_valid, .rd_resp_ready,
        .wr_line, .wr_line_valid, .wr_line_ready,
        .wr_resp_valid, .error_count(mem_errors)
    );

    // ==========================================================
    // Helpers
    // ==========================================================

    // Control word: bursts at 47:32, offset at 31:16, length at 7:0
    function automatic logic [63:0] make_ctrl(input logic [15:0] n, input logic [14:0] start,
                                              input logic [7:0] len);
        return {16'h0, n, 1'b0, start, 8'h0, len};
    endfunction

    // Base OR the offset cut down to the mask
    function automatic mem_test_pkg::t_addr masked_addr(input logic [31:0] base,
            input logic [14:0] start, input int step, input logic [14:0] mask);
        logic [14:0] off;
        off = start + 15'(step);
        return base | 32'(off & mask);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic write_csr(input logic [2:0] idx, input logic [63:0] data);
        @(posedge clk);
        #1;
        csr_wr.valid = 1'b1;
        csr_wr.idx = idx;
        csr_wr.data = data;
        @(posedge clk);
        #1;
        csr_wr.valid = 1'b0;
    endtask

    task automatic read_csr(input logic [2:0] idx, output logic [63:0] data);
        @(posedge clk);
        #1;
        csr_rd_idx = idx;
        #2;
        data = csr_rd_data;
    endtask

    // Checksum and hash folded the way the checker folds them
    task automatic fold_line(input mem_test_pkg::t_line line);
        logic [31:0] sample;
        sample = {line[127:112], line[15:0]};
        exp_sum = exp_sum + sample;
        exp_hash = {exp_hash[26:0], exp_hash[31:27]} ^ sample;
    endtask

    // Bus monitors, mid cycle where every handshake is settled
    always @(negedge clk)
    begin
        if (rd_req_valid && rd_req_ready)
            seen_rd.push_back(rd_req.addr);
        if (wr_line_valid && wr_line_ready)
            seen_wr.push_back(wr_line.addr);
        if (rd_resp_valid && rd_resp_ready)
            fold_line(rd_resp);
    end

    // Run limit from the traffic in the table
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > timeout_limit)
        begin
            $display("Timeout, the engine did not go idle within %0d cycles", timeout_limit);
            $display("Summary: %0d check errors, %0d memory model errors", errors, mem_errors);
            $display("Errors found");
            $finish;
        end
    end

    // ==========================================================
    // Checks
    // ==========================================================

    // Fixed fields after reset and run read back
    task automatic check_config();
        logic [63:0] st;
        read_csr(3'd0, st);
        check_value("status0.addr_low_width", 64'(st[31:16]),
                    64'(mem_test_pkg::ADDR_LOW_WIDTH));
        check_value("status0.max_burst", 64'(st[14:0]), 64'd128);
        check_value("status0.run", 64'(st[33]), 64'd0);
        check_value("status0.active", 64'(st[34]), 64'd0);
        check_value("status0.engine_type", 64'(st[37:35]), 64'd1);
        check_value("status0.ordered", 64'(st[39]), 64'd1);
        write_csr(mem_test_pkg::CSR_CMD, 64'h2);
        read_csr(3'd0, st);
        check_value("status0.run", 64'(st[33]), 64'd1);
        write_csr(mem_test_pkg::CSR_CMD, 64'h0);
        read_csr(3'd0, st);
        check_value("status0.run", 64'(st[33]), 64'd0);
    endtask

    task automatic check_addrs(input t_row row);
        int k;
        check_value("rd_req count", 64'(seen_rd.size()), 64'(row.exp_rd_bursts));
        for (k = 0; k < int'(row.exp_rd_bursts) && k < seen_rd.size(); k++)
            check_value($sformatf("rd_req.addr[%0d]", k), 64'(seen_rd[k]),
                        64'(masked_addr(row.rd_base, row.rd_start, k * int'(row.rd_len),
                                        row.mask)));
        check_value("wr_line count", 64'(seen_wr.size()), 64'(row.exp_wr_lines));
        for (k = 0; k < int'(row.exp_wr_lines) && k < seen_wr.size(); k++)
            check_value($sformatf("wr_line.addr[%0d]", k), 64'(seen_wr[k]),
                        64'(masked_addr(row.wr_base, row.wr_start, k, row.mask)));
    endtask

    // Program, start, wait for idle and compare the statuses
    task automatic run_row(input t_row row);
        logic [63:0] st;
        write_csr(mem_test_pkg::CSR_RD_BASE, 64'(row.rd_base));
        write_csr(mem_test_pkg::CSR_WR_BASE, 64'(row.wr_base));
        write_csr(mem_test_pkg::CSR_RD_CTRL, make_ctrl(row.rd_n, row.rd_start, row.rd_len));
        write_csr(mem_test_pkg::CSR_WR_CTRL, make_ctrl(row.wr_n, row.wr_start, row.wr_len));
        write_csr(mem_test_pkg::CSR_MASK, 64'(row.mask));
        seen_rd.delete();
        seen_wr.delete();
        exp_sum = '0;
        exp_hash = '0;
        rand_ready = row.rand_ready;
        write_csr(mem_test_pkg::CSR_CMD, 64'h3);
        // Active rises after the start pulse and falls once drained
        @(posedge clk);
        #1;
        while (!active)
        begin
            @(posedge clk);
            #1;
        end
        while (active)
        begin
            @(posedge clk);
            #1;
        end
        rand_ready = 1'b0;
        read_csr(3'd1, st);
        check_value("status1.rd_bursts", st, 64'(row.exp_rd_bursts));
        read_csr(3'd2, st);
        check_value("status2.rd_lines", st, 64'(row.exp_rd_lines));
        read_csr(3'd3, st);
        check_value("status3.wr_lines", st, 64'(row.exp_wr_lines));
        read_csr(3'd4, st);
        check_value("status4.wr_bursts", st, 64'(row.exp_wr_bursts));
        read_csr(3'd5, st);
        check_value("status5.sum_hash", st, {exp_sum, exp_hash});
        check_addrs(row);
    endtask

    // ==========================================================
    // Test flow
    // ==========================================================

    initial
    begin
        int r;
        // Read only, write only, then both with a small wrapping mask
        rows[0] = '{32'h0010_0000, 16'd4, 15'h0010, 8'd8, 32'h0, 16'd0, 15'h0, 8'd1,
                    15'h7fff, 1'b0, 16'd4, 16'd32, 16'd0, 16'd0};
        rows[1] = '{32'h0, 16'd0, 15'h0, 8'd1, 32'h0020_0000, 16'd3, 15'h0040, 8'd5,
                    15'h7fff, 1'b0, 16'd0, 16'd0, 16'd15, 16'd3};
        rows[2] = '{32'h0030_0000, 16'd6, 15'h000c, 8'd4, 32'h0040_0000, 16'd4, 15'h001a,
                    8'd3, 15'h001f, 1'b0, 16'd6, 16'd24, 16'd12, 16'd4};
        for (r = 0; r < 3; r++)
        begin
            rows[r + 3] = rows[r];
            rows[r + 3].rand_ready = 1'b1;
        end
        timeout_limit = 200;
        for (r = 0; r < NUM_ROWS; r++)
            timeout_limit += 8 * (int'(rows[r].rd_n) * int'(rows[r].rd_len) +
                                  int'(rows[r].wr_n) * int'(rows[r].wr_len));

        csr_wr = '0;
        csr_rd_idx = 3'd0;
        rand_ready = 1'b0;
        exp_sum = '0;
        exp_hash = '0;
        state_reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        state_reset = 1'b0;

        check_config();
        for (r = 0; r < NUM_ROWS; r++)
            run_row(rows[r]);

        $display("Summary: %0d check errors, %0d memory model errors", errors, mem_errors);
        if (errors == 0 && mem_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: src.f
hw/mem_test_pkg.sv
hw/line_fifo.sv
hw/csr_regs.sv
hw/rd_req_gen.sv
hw/wr_burst_gen.sv
hw/rd_checker.sv
hw/mem_test_engine.sv
tests/host_mem_model.sv
tests/tb_mem_test_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory test engine simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_mem_test_engine -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -qx "No errors" sim.log
